//--- fsab_mem.f
hw/fsab_mem_pkg.sv
hw/sync_fifo.sv
hw/fsab_write_capture.sv
hw/mem_cmd_ctl.sv
hw/read_return.sv
hw/fsab_mem.sv
tests/tb_clk_gen.sv
tests/tb_checker.sv
tests/tb_fsab_mem.sv

//--- run.sh
#!/bin/sh
# Build and run the FSAB bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f fsab_mem.f --top-module tb_fsab_mem -o tb_fsab_mem
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/tb_fsab_mem > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^>>> PASS$' sim.log; then
	exit 0
fi
exit 1

//--- tests/tb_fsab_mem.sv
`default_nettype none

module tb_fsab_mem import fsab_mem_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [3:0] test;
		fsab_mode_t mode;
		fsab_did_t  did;
		fsab_did_t  subdid;
		fsab_addr_t addr;	// Zero picks a random address
		fsab_len_t  len;	// Zero picks a random length
		logic       stall_init;
		logic       stall_af;
		logic       wdf_toggle;
	} stim_t;

	localparam int N_STIM  = 13;
	localparam int TIMEOUT = 3000;
	localparam stim_t STIM [N_STIM] = '{
		'{4'd1, FSAB_WRITE, 4'd1, 4'd2, 31'h1000, 4'd1, 1'b0, 1'b0, 1'b0},
		'{4'd2, FSAB_WRITE, 4'd3, 4'd4, 31'h2000, 4'd8, 1'b0, 1'b0, 1'b1},
		'{4'd3, FSAB_READ,  4'd5, 4'd6, 31'h2000, 4'd8, 1'b0, 1'b0, 1'b0},
		'{4'd4, FSAB_WRITE, 4'd7, 4'd8, 31'h3000, 4'd3, 1'b1, 1'b0, 1'b0},
		'{4'd4, FSAB_READ,  4'd9, 4'd10, 31'h3000, 4'd4, 1'b0, 1'b1, 1'b0},
		'{4'd5, FSAB_WRITE, 4'd1, 4'd1, 31'h0, 4'd0, 1'b0, 1'b0, 1'b0},
		'{4'd5, FSAB_WRITE, 4'd2, 4'd3, 31'h0, 4'd0, 1'b0, 1'b0, 1'b0},
		'{4'd5, FSAB_READ,  4'd3, 4'd5, 31'h0, 4'd0, 1'b0, 1'b0, 1'b0},
		'{4'd5, FSAB_WRITE, 4'd4, 4'd7, 31'h0, 4'd0, 1'b0, 1'b0, 1'b0},
		'{4'd5, FSAB_READ,  4'd5, 4'd9, 31'h0, 4'd0, 1'b0, 1'b0, 1'b0},
		'{4'd5, FSAB_READ,  4'd6, 4'd11, 31'h0, 4'd0, 1'b0, 1'b0, 1'b0},
		'{4'd5, FSAB_WRITE, 4'd7, 4'd13, 31'h0, 4'd0, 1'b0, 1'b0, 1'b0},
		'{4'd5, FSAB_READ,  4'd8, 4'd15, 31'h0, 4'd0, 1'b0, 1'b0, 1'b0}
	};

	logic       clk;
	logic       rst_b;
	logic       fsabo_valid;
	fsab_mode_t fsabo_mode;
	fsab_did_t  fsabo_did;
	fsab_did_t  fsabo_subdid;
	fsab_addr_t fsabo_addr;
	fsab_len_t  fsabo_len;
	fsab_data_t fsabo_data;
	fsab_mask_t fsabo_mask;
	logic       fsabo_credit;
	logic       fsabi_valid;
	fsab_did_t  fsabi_did;
	fsab_did_t  fsabi_subdid;
	fsab_data_t fsabi_data;
	logic       phy_init_done;
	logic       app_af_afull;
	logic       app_wdf_afull;
	logic       app_af_wren;
	mem_cmd_t   app_af_cmd;
	fsab_addr_t app_af_addr;
	logic       app_wdf_wren;
	mem_data_t  app_wdf_data;
	mem_mask_t  app_wdf_mask;
	logic       rd_data_valid;
	mem_data_t  rd_data_fifo_out;
	int         chk_errors;
	int         chk_checks;
	int         chk_resps;
	int         chk_credits;
	int         chk_pending;

	logic [31:0] lfsr = 32'h3cbc_860b;
	logic        wdf_toggle_en = 1'b0;
	int          sent = 0;	// Requests driven
	int          reads_sent = 0;
	int          cycle = 0;
	mem_data_t   model_mem [int];	// Word-addressed controller memory
	int          wr_len_q [$];
	int          rd_len_q [$];
	int          wword_q [$];
	mem_data_t   rd_word_q [$];
	int          rd_words_q [$];
	int          rd_due_q [$];
	int          burst_left = 0;

	tb_clk_gen clk_gen (.clk, .rst_b);

	fsab_mem uut (
		.clk, .rst_b,
		.fsabo_valid, .fsabo_mode, .fsabo_did, .fsabo_subdid,
		.fsabo_addr, .fsabo_len, .fsabo_data, .fsabo_mask, .fsabo_credit,
		.fsabi_valid, .fsabi_did, .fsabi_subdid, .fsabi_data,
		.phy_init_done, .app_af_afull, .app_wdf_afull,
		.app_af_wren, .app_af_cmd, .app_af_addr,
		.app_wdf_wren, .app_wdf_data, .app_wdf_mask,
		.rd_data_valid, .rd_data_fifo_out
	);

	tb_checker chk (
		.clk, .rst_b,
		.fsabo_valid, .fsabo_mode, .fsabo_did, .fsabo_subdid,
		.fsabo_addr, .fsabo_len, .fsabo_data, .fsabo_mask, .fsabo_credit,
		.fsabi_valid, .fsabi_did, .fsabi_subdid, .fsabi_data,
		.phy_init_done, .app_af_afull, .app_wdf_afull,
		.app_af_wren, .app_af_cmd, .app_af_addr,
		.app_wdf_wren, .app_wdf_data, .app_wdf_mask,
		.errors (chk_errors), .checks (chk_checks),
		.resps (chk_resps), .credits (chk_credits),
		.pending (chk_pending)
	);

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic mem_data_t mem_fill(input int w);
		return {4{w ^ 32'h5a0f_c3e1}};
	endfunction

	task automatic abort_run(input string what);
		$display("timeout: %s", what);
		$display(">>> FAIL");
		$finish;
	endtask

	// Controller model takes commands and write words
	always @(posedge clk) begin : model_absorb
		int        n;
		int        w;
		int        a;
		mem_data_t cur;
		cycle++;
		if (rst_b && app_af_wren) begin
			if (app_af_cmd == MEM_CMD_WRITE && wr_len_q.size() != 0) begin
				n = wr_len_q.pop_front();
				for (int i = 0; i < (n + 1) / 2; i++)
					wword_q.push_back(int'(app_af_addr >> 4) + i);
			end else if (app_af_cmd == MEM_CMD_READ && rd_len_q.size() != 0) begin
				n = rd_len_q.pop_front();
				a = int'(app_af_addr >> 4);
				for (int i = 0; i < (n + 1) / 2; i++)	// Read sees memory as of the command
					rd_word_q.push_back(model_mem.exists(a + i) ? model_mem[a + i] :
					                                              mem_fill(a + i));
				rd_words_q.push_back((n + 1) / 2);
				rd_due_q.push_back(cycle + 1 + int'(rand_bits(3)));	// 1 to 8 cycles
			end
		end
		if (rst_b && app_wdf_wren && wword_q.size() != 0) begin
			w   = wword_q.pop_front();
			cur = model_mem.exists(w) ? model_mem[w] : mem_fill(w);
			for (int b = 0; b < 16; b++)
				if (!app_wdf_mask[b])
					cur[8 * b +: 8] = app_wdf_data[8 * b +: 8];
			model_mem[w] = cur;
		end
	end

	// Read words go back one per cycle once due
	always @(negedge clk) begin
		rd_data_valid = 1'b0;
		if (burst_left == 0 && rd_words_q.size() != 0 && cycle >= rd_due_q[0]) begin
			burst_left = rd_words_q.pop_front();
			void'(rd_due_q.pop_front());
		end
		if (burst_left != 0) begin
			rd_data_valid    = 1'b1;
			rd_data_fifo_out = rd_word_q.pop_front();
			burst_left--;
		end
	end

	always @(negedge clk)
		app_wdf_afull = wdf_toggle_en ? (rand_bits(1) != 0) : 1'b0;

	task automatic drive_request(input stim_t s);
		fsab_len_t  len;
		fsab_addr_t addr;
		int         beats;
		int         waited;
		len    = (s.len != 4'd0) ? s.len : fsab_len_t'(rand_bits(3)) + 4'd1;
		addr   = (s.addr != 31'h0) ? s.addr : 31'h4000 + fsab_addr_t'(rand_bits(2) << 6);
		beats  = (s.mode == FSAB_WRITE) ? int'(len) : 1;
		waited = 0;
		while (sent - chk_credits >= FSAB_CREDITS) begin	// Out of credits
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT)
				abort_run("no credit came back from the bridge");
		end
		if (s.mode == FSAB_WRITE) begin
			wr_len_q.push_back(int'(len));
		end else begin
			rd_len_q.push_back(int'(len));
			reads_sent++;
		end
		sent++;
		for (int k = 0; k < beats; k++) begin
			@(negedge clk);
			if (s.test == 4'd5 && k != 0 && rand_bits(1) != 0) begin	// Gap beat
				fsabo_valid = 1'b0;
				@(negedge clk);
			end
			fsabo_valid  = 1'b1;
			fsabo_mode   = s.mode;
			fsabo_did    = s.did;
			fsabo_subdid = s.subdid;
			fsabo_addr   = addr;
			fsabo_len    = len;
			fsabo_data   = (s.mode == FSAB_WRITE) ? {rand_bits(32), rand_bits(32)} : '0;
			fsabo_mask   = fsab_mask_t'(rand_bits(8) & rand_bits(8));
		end
		@(negedge clk);
		fsabo_valid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while (chk_credits != sent || chk_resps != reads_sent || chk_pending != 0) begin
			@(negedge clk);
			waited++;
			if (waited > TIMEOUT)
				abort_run("requests did not complete");
		end
	endtask

	initial begin
		stim_t s;
		int    waited;
		int    base_errors;
		int    base_checks;
		fsabo_valid      = 1'b0;
		fsabo_mode       = FSAB_READ;
		fsabo_did        = '0;
		fsabo_subdid     = '0;
		fsabo_addr       = '0;
		fsabo_len        = '0;
		fsabo_data       = '0;
		fsabo_mask       = '0;
		phy_init_done    = 1'b0;
		app_af_afull     = 1'b0;
		app_wdf_afull    = 1'b0;
		rd_data_valid    = 1'b0;
		rd_data_fifo_out = '0;
		base_errors      = 0;
		base_checks      = 0;
		waited           = 0;
		while (!rst_b) begin
			@(negedge clk);
			waited++;
			if (waited > 100)
				abort_run("reset never released");
		end
		for (int i = 0; i < 3; i++)
			@(negedge clk);
		phy_init_done = 1'b1;

		for (int r = 0; r < N_STIM; r++) begin
			s             = STIM[r];
			wdf_toggle_en = s.wdf_toggle;
			if (s.stall_init)
				phy_init_done = 1'b0;
			if (s.stall_af)
				app_af_afull = 1'b1;
			drive_request(s);
			if (s.stall_init || s.stall_af) begin
				for (int i = 0; i < 12; i++)	// Hold the request back
					@(negedge clk);
				phy_init_done = 1'b1;
				app_af_afull  = 1'b0;
			end
			if (r == N_STIM - 1 || STIM[r + 1].test != s.test) begin
				drain();
				wdf_toggle_en = 1'b0;
				$display("test %0d done: %0d checks, %0d errors", s.test,
				         chk_checks - base_checks, chk_errors - base_errors);
				base_checks = chk_checks;
				base_errors = chk_errors;
			end
		end

		if (chk_credits != sent)
			$display("mismatch at %0t: fsabo_credit count got %0d expected %0d",
			         $time, chk_credits, sent);
		$display("summary: %0d checks, %0d errors, %0d requests, %0d credits",
		         chk_checks, chk_errors, sent, chk_credits);
		if (chk_errors == 0 && chk_credits == sent)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/tb_checker.sv
`default_nettype none

module tb_checker import fsab_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_b,
	input  logic       fsabo_valid,
	input  fsab_mode_t fsabo_mode,
	input  fsab_did_t  fsabo_did,
	input  fsab_did_t  fsabo_subdid,
	input  fsab_addr_t fsabo_addr,
	input  fsab_len_t  fsabo_len,
	input  fsab_data_t fsabo_data,
	input  fsab_mask_t fsabo_mask,
	input  logic       fsabo_credit,
	input  logic       fsabi_valid,
	input  fsab_did_t  fsabi_did,
	input  fsab_did_t  fsabi_subdid,
	input  fsab_data_t fsabi_data,
	input  logic       phy_init_done,
	input  logic       app_af_afull,
	input  logic       app_wdf_afull,
	input  logic       app_af_wren,
	input  mem_cmd_t   app_af_cmd,
	input  fsab_addr_t app_af_addr,
	input  logic       app_wdf_wren,
	input  mem_data_t  app_wdf_data,
	input  mem_mask_t  app_wdf_mask,
	output int         errors,
	output int         checks,
	output int         resps,
	output int         credits,
	output int         pending
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [7:0] ref_mem [int];	// Byte image of everything written
	mem_cmd_t   exp_cmd_q [$];
	fsab_addr_t exp_addr_q [$];
	int         exp_clen_q [$];
	mem_data_t  exp_wdata_q [$];
	mem_mask_t  exp_wmask_q [$];
	fsab_data_t exp_beat_q [$];
	fsab_did_t  exp_did_q [$];
	fsab_did_t  exp_sub_q [$];
	int         exp_rlen_q [$];
	int         cap_rem;	// Write beats still to come
	int         cap_k;
	int         cap_base;
	int         resp_rem;
	int         wwords_left;	// Words left in the current write burst
	logic       credit_due;
	fsab_data_t held_data;
	fsab_mask_t held_mask;

	initial begin
		errors      = 0;
		checks      = 0;
		resps       = 0;
		credits     = 0;
		pending     = 0;
		cap_rem     = 0;
		resp_rem    = 0;
		wwords_left = 0;
		credit_due  = 1'b0;
	end

	function automatic mem_data_t mem_fill(input int w);
		return {4{w ^ 32'h5a0f_c3e1}};	// Unwritten memory pattern
	endfunction

	function automatic logic [7:0] ref_byte(input int a);
		mem_data_t f;
		f = mem_fill(a >> 4);
		return ref_mem.exists(a) ? ref_mem[a] : f[8 * (a & 15) +: 8];
	endfunction

	task automatic report_failure(input string what);
		$display("error at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic compare(input string sig, input logic [127:0] got, input logic [127:0] exp);
		checks++;
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, sig, got, exp);
			errors++;
		end
	endtask

	task automatic capture_beat();
		fsab_data_t beat;
		if (cap_rem == 0) begin	// Header beat
			exp_cmd_q.push_back(fsabo_mode == FSAB_WRITE ? MEM_CMD_WRITE : MEM_CMD_READ);
			exp_addr_q.push_back(fsabo_addr);
			exp_clen_q.push_back(int'(fsabo_len));
			cap_base = int'(fsabo_addr >> 4) * 16;
			cap_k    = 0;
			if (fsabo_mode == FSAB_READ) begin
				for (int k = 0; k < int'(fsabo_len); k++) begin
					for (int b = 0; b < 8; b++)
						beat[8 * b +: 8] = ref_byte(cap_base + 8 * k + b);
					exp_beat_q.push_back(beat);
					exp_did_q.push_back(fsabo_did);
					exp_sub_q.push_back(fsabo_subdid);
				end
				exp_rlen_q.push_back(int'(fsabo_len));
				return;
			end
			cap_rem = int'(fsabo_len);
		end
		for (int b = 0; b < 8; b++)
			if (!fsabo_mask[b])
				ref_mem[cap_base + 8 * cap_k + b] = fsabo_data[8 * b +: 8];
		if (cap_k % 2 == 1) begin
			exp_wdata_q.push_back({fsabo_data, held_data});
			exp_wmask_q.push_back({fsabo_mask, held_mask});
		end else if (cap_rem == 1) begin	// Odd tail
			exp_wdata_q.push_back({64'b0, fsabo_data});
			exp_wmask_q.push_back({8'hff, fsabo_mask});
		end else begin
			held_data = fsabo_data;
			held_mask = fsabo_mask;
		end
		cap_k++;
		cap_rem--;
	endtask

	always @(posedge clk) begin : watch
		logic [127:0] keep;
		logic         credit_next;
		if (rst_b) begin
			credit_next = 1'b0;
			// Credit comes the cycle after the last memory beat
			if (fsabo_credit || credit_due)
				compare("fsabo_credit", 128'(fsabo_credit), 128'(credit_due));
			if (fsabo_valid)
				capture_beat();
			if (app_af_wren) begin
				if (!phy_init_done)
					report_failure("command issued while phy_init_done was low");
				if (app_af_afull)
					report_failure("command issued while app_af_afull was high");
				if (exp_cmd_q.size() == 0) begin
					report_failure("command issued with no request captured");
				end else begin
					if (exp_cmd_q[0] == MEM_CMD_READ)
						credit_next = 1'b1;
					else
						wwords_left = (exp_clen_q[0] + 1) / 2;
					compare("app_af_cmd", 128'(app_af_cmd), 128'(exp_cmd_q.pop_front()));
					compare("app_af_addr", 128'(app_af_addr), 128'(exp_addr_q.pop_front()));
					void'(exp_clen_q.pop_front());
				end
			end
			if (app_wdf_wren) begin
				if (app_wdf_afull)
					report_failure("write data sent while app_wdf_afull was high");
				if (exp_wdata_q.size() == 0) begin
					report_failure("write word sent with no write beats captured");
				end else begin
					compare("app_wdf_mask", 128'(app_wdf_mask), 128'(exp_wmask_q[0]));
					for (int b = 0; b < 16; b++)
						keep[8 * b +: 8] = exp_wmask_q[0][b] ? 8'h00 : 8'hff;
					compare("app_wdf_data", app_wdf_data & keep, exp_wdata_q[0] & keep);
					void'(exp_wdata_q.pop_front());
					void'(exp_wmask_q.pop_front());
					if (wwords_left > 0) begin
						wwords_left--;
						if (wwords_left == 0)
							credit_next = 1'b1;
					end
				end
			end
			if (resp_rem != 0 && !fsabi_valid) begin
				report_failure("response stopped before its last beat");
				resp_rem = 0;
			end
			if (fsabi_valid) begin
				if (resp_rem == 0 && exp_rlen_q.size() != 0)
					resp_rem = exp_rlen_q.pop_front();
				if (exp_beat_q.size() == 0) begin
					report_failure("response beat with no read outstanding");
				end else begin
					compare("fsabi_data", 128'(fsabi_data), 128'(exp_beat_q.pop_front()));
					compare("fsabi_did", 128'(fsabi_did), 128'(exp_did_q.pop_front()));
					compare("fsabi_subdid", 128'(fsabi_subdid), 128'(exp_sub_q.pop_front()));
					resp_rem--;
					if (resp_rem == 0)
						resps++;
				end
			end
			if (fsabo_credit)
				credits++;
			credit_due = credit_next;
			pending    = exp_cmd_q.size() + exp_wdata_q.size() + exp_beat_q.size();
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`default_nettype none

module tb_clk_gen (
	output logic clk,
	output logic rst_b
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 4;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	initial begin
		rst_b = 1'b0;
		for (int i = 0; i < RESET_CYCLES; i++)
			@(posedge clk);
		@(negedge clk);
		rst_b = 1'b1;
	end

endmodule

`default_nettype wire

//--- hw/fsab_mem.sv
`default_nettype none

module fsab_mem import fsab_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_b,
	// FSAB requests in
	input  logic       fsabo_valid,
	input  fsab_mode_t fsabo_mode,
	input  fsab_did_t  fsabo_did,
	input  fsab_did_t  fsabo_subdid,
	input  fsab_addr_t fsabo_addr,
	input  fsab_len_t  fsabo_len,
	input  fsab_data_t fsabo_data,
	input  fsab_mask_t fsabo_mask,
	output logic       fsabo_credit,
	// FSAB responses out
	output logic       fsabi_valid,
	output fsab_did_t  fsabi_did,
	output fsab_did_t  fsabi_subdid,
	output fsab_data_t fsabi_data,
	// DDR2 controller application port
	input  logic       phy_init_done,
	input  logic       app_af_afull,
	input  logic       app_wdf_afull,
	output logic       app_af_wren,
	output mem_cmd_t   app_af_cmd,
	output fsab_addr_t app_af_addr,
	output logic       app_wdf_wren,
	output mem_data_t  app_wdf_data,
	output mem_mask_t  app_wdf_mask,
	input  logic       rd_data_valid,
	input  mem_data_t  rd_data_fifo_out
);
	logic       req_ready;
	fsab_mode_t head_mode;
	fsab_did_t  head_did;
	fsab_did_t  head_subdid;
	fsab_addr_t head_addr;
	fsab_len_t  head_len;
	mem_data_t  word_data;
	mem_mask_t  word_mask;
	logic       req_pop;
	logic       word_pop;
	logic       rd_room;
	logic       rd_tag_push;
	fsab_did_t  rd_tag_did;
	fsab_did_t  rd_tag_subdid;
	fsab_len_t  rd_tag_len;

	fsab_write_capture u_capture (
		.clk, .rst_b,
		.fsabo_valid, .fsabo_mode, .fsabo_did, .fsabo_subdid,
		.fsabo_addr, .fsabo_len, .fsabo_data, .fsabo_mask,
		.req_pop, .word_pop, .req_ready,
		.head_mode, .head_did, .head_subdid, .head_addr, .head_len,
		.word_data, .word_mask
	);

	mem_cmd_ctl u_ctl (
		.clk, .rst_b,
		.req_ready, .head_mode, .head_did, .head_subdid, .head_addr, .head_len,
		.word_data, .word_mask,
		.phy_init_done, .app_af_afull, .app_wdf_afull, .rd_room,
		.req_pop, .word_pop,
		.app_af_wren, .app_af_cmd, .app_af_addr,
		.app_wdf_wren, .app_wdf_data, .app_wdf_mask,
		.fsabo_credit,
		.rd_tag_push, .rd_tag_did, .rd_tag_subdid, .rd_tag_len
	);

	read_return u_return (
		.clk, .rst_b,
		.rd_tag_push, .rd_tag_did, .rd_tag_subdid, .rd_tag_len,
		.rd_data_valid, .rd_data_fifo_out,
		.rd_room,
		.fsabi_valid, .fsabi_did, .fsabi_subdid, .fsabi_data
	);

endmodule

`default_nettype wire

//--- hw/read_return.sv
`default_nettype none

module read_return import fsab_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_b,
	input  logic       rd_tag_push,
	input  fsab_did_t  rd_tag_did,
	input  fsab_did_t  rd_tag_subdid,
	input  fsab_len_t  rd_tag_len,
	input  logic       rd_data_valid,
	input  mem_data_t  rd_data_fifo_out,
	output logic       rd_room,
	output logic       fsabi_valid,
	output fsab_did_t  fsabi_did,
	output fsab_did_t  fsabi_subdid,
	output fsab_data_t fsabi_data
);
	localparam int OCW = $clog2(RD_MAX_OUTSTANDING + 1);
	localparam int DCW = $clog2(RDATA_DEPTH + 1);

	logic [OCW-1:0] outstanding;	// Reads issued and not yet returned
	logic [DCW-1:0] data_count;
	logic           tag_empty;
	logic           tag_pop;
	logic           tag_loaded;	// Head tag sits on the FIFO output
	fsab_len_t      tag_len;
	fsab_len_t      words_needed;
	fsab_len_t      beats_rem;
	logic           busy;
	logic           upper;	// Upper half of current word
	logic           start;
	logic           word_pop;
	logic           resp_done;
	mem_data_t      word;

	assign rd_room      = (outstanding < OCW'(RD_MAX_OUTSTANDING));
	assign words_needed = fsab_len_t'((tag_len + 4'd1) >> 1);
	assign tag_pop      = !tag_loaded && !tag_empty;
	assign start        = tag_loaded && !busy && (data_count >= DCW'(words_needed));
	assign resp_done    = busy && (beats_rem == 4'd1);

	// Next word comes out as the upper half goes
	assign word_pop = start || (busy && upper && !resp_done);

	assign fsabi_valid = busy;
	assign fsabi_data  = upper ? word[127:64] : word[63:0];

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			outstanding <= '0;
			tag_loaded  <= 1'b0;
			busy        <= 1'b0;
			upper       <= 1'b0;
			beats_rem   <= '0;
		end else begin
			if (rd_tag_push && !resp_done)
				outstanding <= outstanding + 1'b1;
			else if (resp_done && !rd_tag_push)
				outstanding <= outstanding - 1'b1;
			if (tag_pop)
				tag_loaded <= 1'b1;
			else if (resp_done)
				tag_loaded <= 1'b0;
			if (start) begin
				busy      <= 1'b1;
				beats_rem <= tag_len;
				upper     <= 1'b0;
			end else if (busy) begin
				beats_rem <= beats_rem - 1'b1;
				upper     <= !upper;
				if (resp_done)
					busy <= 1'b0;
			end
		end
	end

	sync_fifo #(.WIDTH(TAG_FIFO_W), .DEPTH(RD_MAX_OUTSTANDING)) tag_fifo (
		.clk   (clk),
		.rst_b (rst_b),
		.wr    (rd_tag_push),
		.wdata ({rd_tag_did, rd_tag_subdid, rd_tag_len}),
		.rd    (tag_pop),
		.rdata ({fsabi_did, fsabi_subdid, tag_len}),
		.count (),
		.full  (),
		.empty (tag_empty)
	);

	sync_fifo #(.WIDTH($bits(mem_data_t)), .DEPTH(RDATA_DEPTH)) data_fifo (
		.clk   (clk),
		.rst_b (rst_b),
		.wr    (rd_data_valid),
		.wdata (rd_data_fifo_out),
		.rd    (word_pop),
		.rdata (word),
		.count (data_count),
		.full  (),
		.empty ()
	);

endmodule

`default_nettype wire

//--- hw/mem_cmd_ctl.sv
`default_nettype none

module mem_cmd_ctl import fsab_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_b,
	input  logic       req_ready,
	input  fsab_mode_t head_mode,
	input  fsab_did_t  head_did,
	input  fsab_did_t  head_subdid,
	input  fsab_addr_t head_addr,
	input  fsab_len_t  head_len,
	input  mem_data_t  word_data,
	input  mem_mask_t  word_mask,
	input  logic       phy_init_done,
	input  logic       app_af_afull,
	input  logic       app_wdf_afull,
	input  logic       rd_room,
	output logic       req_pop,
	output logic       word_pop,
	output logic       app_af_wren,
	output mem_cmd_t   app_af_cmd,
	output fsab_addr_t app_af_addr,
	output logic       app_wdf_wren,
	output mem_data_t  app_wdf_data,
	output mem_mask_t  app_wdf_mask,
	output logic       fsabo_credit,
	output logic       rd_tag_push,
	output fsab_did_t  rd_tag_did,
	output fsab_did_t  rd_tag_subdid,
	output fsab_len_t  rd_tag_len
);
	ctl_state_t state;
	fsab_len_t  words_rem;	// Memory words left in the burst
	logic       is_write;
	logic       can_issue;
	logic       issue;
	logic       last_word;

	assign is_write  = (head_mode == FSAB_WRITE);
	assign can_issue = phy_init_done && !app_af_afull && (is_write || rd_room);
	assign issue     = (state == ISSUE) && can_issue;

	// Head fields are valid from the cycle after req_pop
	assign req_pop     = (state == IDLE) && req_ready;
	assign app_af_wren = issue;
	assign app_af_cmd  = is_write ? MEM_CMD_WRITE : MEM_CMD_READ;
	assign app_af_addr = head_addr;

	assign app_wdf_wren = (state == WBURST) && !app_wdf_afull;
	assign app_wdf_data = word_data;
	assign app_wdf_mask = word_mask;
	assign last_word    = app_wdf_wren && (words_rem == 4'd1);

	// First word is fetched at issue, the rest one ahead of use
	assign word_pop = (issue && is_write) || (app_wdf_wren && !last_word);

	assign rd_tag_push   = issue && !is_write;
	assign rd_tag_did    = head_did;
	assign rd_tag_subdid = head_subdid;
	assign rd_tag_len    = head_len;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			state        <= IDLE;
			words_rem    <= '0;
			fsabo_credit <= 1'b0;
		end else begin
			fsabo_credit <= rd_tag_push || last_word;	// Request has left the bridge
			case (state)
				IDLE: begin
					if (req_ready)
						state <= ISSUE;
				end
				ISSUE: begin
					if (can_issue) begin
						state     <= is_write ? WBURST : IDLE;
						words_rem <= fsab_len_t'((head_len + 4'd1) >> 1);
					end
				end
				WBURST: begin
					if (app_wdf_wren) begin
						words_rem <= words_rem - 1'b1;
						if (last_word)
							state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/fsab_write_capture.sv
`default_nettype none

module fsab_write_capture import fsab_mem_pkg::*; (
	input  logic       clk,
	input  logic       rst_b,
	input  logic       fsabo_valid,
	input  fsab_mode_t fsabo_mode,
	input  fsab_did_t  fsabo_did,
	input  fsab_did_t  fsabo_subdid,
	input  fsab_addr_t fsabo_addr,
	input  fsab_len_t  fsabo_len,
	input  fsab_data_t fsabo_data,
	input  fsab_mask_t fsabo_mask,
	input  logic       req_pop,
	input  logic       word_pop,
	output logic       req_ready,
	output fsab_mode_t head_mode,
	output fsab_did_t  head_did,
	output fsab_did_t  head_subdid,
	output fsab_addr_t head_addr,
	output fsab_len_t  head_len,
	output mem_data_t  word_data,
	output mem_mask_t  word_mask
);
	fsab_len_t                         beats_rem;	// Beats left in current write
	logic                              half;	// Lower beat waiting in prev
	fsab_data_t                        prev_data;
	fsab_mask_t                        prev_mask;
	logic [$clog2(FSAB_CREDITS+1)-1:0] queued;	// Fully captured requests
	logic                              new_req;
	logic                              wr_beat;
	logic                              last_beat;
	logic                              word_push;
	logic                              req_done;
	mem_data_t                         push_data;
	mem_mask_t                         push_mask;
	logic [REQ_FIFO_W-1:0]             req_rdata;

	assign new_req   = fsabo_valid && (beats_rem == '0);
	assign wr_beat   = fsabo_valid && ((beats_rem != '0) || (fsabo_mode == FSAB_WRITE));
	assign last_beat = new_req ? (fsabo_len == 4'd1) : (beats_rem == 4'd1);
	assign word_push = wr_beat && (half || last_beat);
	assign req_done  = (new_req && (fsabo_mode == FSAB_READ)) || (wr_beat && last_beat);

	// Odd tail leaves the upper half fully masked
	assign push_data = half ? {fsabo_data, prev_data} : {fsab_data_t'(0), fsabo_data};
	assign push_mask = half ? {fsabo_mask, prev_mask} :
	                          {{$bits(fsab_mask_t){1'b1}}, fsabo_mask};

	assign req_ready = (queued != '0);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			beats_rem <= '0;
			half      <= 1'b0;
			queued    <= '0;
		end else begin
			if (new_req && (fsabo_mode == FSAB_WRITE))
				beats_rem <= fsabo_len - 1'b1;	// Header beat counts as one
			else if (fsabo_valid && (beats_rem != '0))
				beats_rem <= beats_rem - 1'b1;
			if (wr_beat)
				half <= !half && !last_beat;
			if (req_done && !req_pop)
				queued <= queued + 1'b1;
			else if (req_pop && !req_done)
				queued <= queued - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_beat && !half) begin
			prev_data <= fsabo_data;
			prev_mask <= fsabo_mask;
		end
	end

	sync_fifo #(.WIDTH(REQ_FIFO_W), .DEPTH(FSAB_CREDITS)) req_fifo (
		.clk   (clk),
		.rst_b (rst_b),
		.wr    (new_req),
		.wdata ({fsabo_mode, fsabo_did, fsabo_subdid, fsabo_addr, fsabo_len}),
		.rd    (req_pop),
		.rdata (req_rdata),
		.count (),
		.full  (),
		.empty ()
	);

	assign {head_mode, head_did, head_subdid, head_addr, head_len} = req_rdata;

	sync_fifo #(.WIDTH(WORD_FIFO_W), .DEPTH(WDATA_DEPTH)) word_fifo (
		.clk   (clk),
		.rst_b (rst_b),
		.wr    (word_push),
		.wdata ({push_data, push_mask}),
		.rd    (word_pop),
		.rdata ({word_data, word_mask}),
		.count (),
		.full  (),
		.empty ()
	);

endmodule

`default_nettype wire

//--- hw/sync_fifo.sv
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  logic                       clk,
	input  logic                       rst_b,
	input  logic                       wr,
	input  logic [WIDTH-1:0]           wdata,
	input  logic                       rd,
	output logic [WIDTH-1:0]           rdata,
	output logic [$clog2(DEPTH+1)-1:0] count,
	output logic                       full,
	output logic                       empty
);
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic             do_wr;
	logic             do_rd;

	assign full  = (count == ($clog2(DEPTH+1))'(DEPTH));
	assign empty = (count == '0);
	assign do_wr = wr && !full;	// Overflow drops the entry
	assign do_rd = rd && !empty;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= wdata;
		if (do_rd)
			rdata <= mem[rd_ptr];	// Holds until next read
	end

endmodule

`default_nettype wire

//--- hw/fsab_mem_pkg.sv
`default_nettype none

package fsab_mem_pkg;

	typedef logic [63:0]  fsab_data_t;
	typedef logic [7:0]   fsab_mask_t;	// Set bit = byte not written
	typedef logic [30:0]  fsab_addr_t;	// Byte address
	typedef logic [3:0]   fsab_did_t;
	typedef logic [3:0]   fsab_len_t;	// Beats, 1 to 8
	typedef logic [0:0]   fsab_mode_t;
	typedef logic [127:0] mem_data_t;	// Two FSAB beats, lower first
	typedef logic [15:0]  mem_mask_t;
	typedef logic [2:0]   mem_cmd_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WBURST
	} ctl_state_t;

	localparam fsab_mode_t FSAB_WRITE = 1'b1;
	localparam fsab_mode_t FSAB_READ  = 1'b0;

	localparam mem_cmd_t MEM_CMD_WRITE = 3'd0;
	localparam mem_cmd_t MEM_CMD_READ  = 3'd1;

	localparam int FSAB_LEN_MAX       = 8;
	localparam int FSAB_CREDITS       = 4;	// Requests outstanding at reset
	localparam int RD_MAX_OUTSTANDING = 2;
	localparam int WDATA_DEPTH        = FSAB_CREDITS * FSAB_LEN_MAX / 2;
	localparam int RDATA_DEPTH        = RD_MAX_OUTSTANDING * FSAB_LEN_MAX / 2;

	// Packed FIFO entry widths
	localparam int REQ_FIFO_W  = $bits(fsab_mode_t) + 2 * $bits(fsab_did_t) +
	                             $bits(fsab_addr_t) + $bits(fsab_len_t);
	localparam int WORD_FIFO_W = $bits(mem_data_t) + $bits(mem_mask_t);
	localparam int TAG_FIFO_W  = 2 * $bits(fsab_did_t) + $bits(fsab_len_t);

endpackage

`default_nettype wire
